//--- clock_panel.f
+incdir+hdl
hdl/clock_panel_pkg.sv
hdl/timer_ctl_if.sv
hdl/panel_control.sv
hdl/bcd_field_editor.sv
hdl/countdown_timer.sv
hdl/digit_formatter.sv
hdl/clock_panel.sv
testbench/clock_panel_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the clock panel testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module clock_panel_tb \
  -f clock_panel.f -o clock_panel_sim || { echo "build failed"; exit 1; }

out=$(./obj_dir/clock_panel_sim)
echo "$out"
echo "$out" | grep -qx "=== PASS ===" && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- testbench/clock_panel_tb.sv
`timescale 1ns/1ps
`include "clock_panel_consts.svh"

module clock_panel_tb;

  localparam int max_presses = 320;  // upper bound over all tests
  localparam int max_ticks   = 80;

  logic                    clk;
  logic                    rst_n;
  clock_panel_pkg::mode_e  mode;
  logic                    tick;
  logic                    up_btn;
  logic                    down_btn;
  logic [`BCD_W-1:0]       time_hour;
  logic [`BCD_W-1:0]       time_minute;
  logic [`BCD_W-1:0]       time_second;
  clock_panel_pkg::digit_t led0, led1, led2, led3, led4, led5, led6, led7;
  logic [`NUM_DIGITS-1:0]  blink;
  logic                    ring;
  logic                    set_time;
  logic [`BCD_W-1:0]       set_hour;
  logic [`BCD_W-1:0]       set_minute;
  logic [`BCD_W-1:0]       set_second;

  integer                  seed = 32'h18a9;
  int                      errors = 0;
  int                      checks = 0;
  int                      set_pulses = 0;
  int                      exp_set_pulses = 0;
  logic                    check_pending = 1'b0;
  logic                    check_set = 1'b0;
  logic                    exp_reset_state = 1'b0;
  clock_panel_pkg::hms_t   exp_hms;
  clock_panel_pkg::hms_t   exp_set;
  clock_panel_pkg::hms_t   exp_preset;
  logic [`NUM_DIGITS-1:0]  exp_blink;
  logic                    exp_ring;

  clock_panel i_clock_panel (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic int rand_below(input int n);
    return {$random(seed)} % n;
  endfunction

  function automatic int bcd_to_bin(input logic [7:0] v);
    return 10 * int'(v[7:4]) + int'(v[3:0]);
  endfunction

  function automatic logic [7:0] bin_to_bcd(input int n);
    return {4'(n / 10), 4'(n % 10)};
  endfunction

  function automatic logic [7:0] field_inc(input logic [7:0] v, input int max);
    int n;
    n = bcd_to_bin(v) + 1;
    if (n > max) n = 0;  // past the limit back to 00
    return bin_to_bcd(n);
  endfunction

  function automatic clock_panel_pkg::hms_t hms_countdown(input clock_panel_pkg::hms_t t,
                                                           input int n);
    clock_panel_pkg::hms_t r;
    int total;
    total = bcd_to_bin(t.hour) * 3600 + bcd_to_bin(t.minute) * 60 + bcd_to_bin(t.second);
    total = (total > n) ? total - n : 0;  // stops at zero
    r.hour   = bin_to_bcd(total / 3600);
    r.minute = bin_to_bcd((total / 60) % 60);
    r.second = bin_to_bcd(total % 60);
    return r;
  endfunction

  // digit 7 is the leftmost
  function automatic clock_panel_pkg::digit_t expected_digit(input clock_panel_pkg::hms_t t,
                                                              input int i);
    case (i)
      7: return t.hour[7:4];
      6: return t.hour[3:0];
      4: return t.minute[7:4];
      3: return t.minute[3:0];
      1: return t.second[7:4];
      0: return t.second[3:0];
      default: return `DIGIT_SEP;
    endcase
  endfunction

  function automatic logic [7:0] blink_for_mode(input clock_panel_pkg::mode_e m, input logic rng);
    case (m)
      clock_panel_pkg::TIME_EDIT_SECOND, clock_panel_pkg::TIMER_EDIT_SECOND: return `BLINK_SECOND;
      clock_panel_pkg::TIME_EDIT_MINUTE, clock_panel_pkg::TIMER_EDIT_MINUTE: return `BLINK_MINUTE;
      clock_panel_pkg::TIME_EDIT_HOUR, clock_panel_pkg::TIMER_EDIT_HOUR: return `BLINK_HOUR;
      clock_panel_pkg::TIMER_DISP: return rng ? `BLINK_ALL : `BLINK_NONE;
      default: return `BLINK_NONE;
    endcase
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic press_button(input logic up);
    if (up) up_btn = 1'b0;
    else down_btn = 1'b0;
    wait_cycles(3);
    up_btn   = 1'b1;
    down_btn = 1'b1;
    wait_cycles(3);
  endtask

  task automatic apply_ticks(input int n);
    repeat (n) begin
      tick = 1'b1;
      wait_cycles(1);
      tick = 1'b0;
      wait_cycles(3);
    end
  endtask

  task automatic request_check();
    check_pending = 1'b1;
    wait (check_pending == 1'b0);
    wait_cycles(1);
  endtask

  task automatic edit_field(input clock_panel_pkg::mode_e m, input int presses);
    mode      = m;
    exp_blink = blink_for_mode(m, exp_ring);
    repeat (presses) begin
      press_button(1'b0);
      case (m)
        clock_panel_pkg::TIME_EDIT_SECOND, clock_panel_pkg::TIMER_EDIT_SECOND:
          exp_hms.second = field_inc(exp_hms.second, bcd_to_bin(`SECOND_MAX));
        clock_panel_pkg::TIME_EDIT_MINUTE, clock_panel_pkg::TIMER_EDIT_MINUTE:
          exp_hms.minute = field_inc(exp_hms.minute, bcd_to_bin(`MINUTE_MAX));
        default:
          exp_hms.hour = field_inc(exp_hms.hour, bcd_to_bin(`HOUR_MAX));
      endcase
    end
    request_check();
  endtask

  // edits start from a zero time so the preset is known
  task automatic preset_timer(input int sec_presses, input int min_presses, input int hour_presses);
    mode        = clock_panel_pkg::TIME_DISP;
    time_hour   = 8'h00;
    time_minute = 8'h00;
    time_second = 8'h00;
    exp_hms     = '0;
    exp_blink   = `BLINK_NONE;
    request_check();
    edit_field(clock_panel_pkg::TIMER_EDIT_SECOND, sec_presses);
    edit_field(clock_panel_pkg::TIMER_EDIT_MINUTE, min_presses);
    edit_field(clock_panel_pkg::TIMER_EDIT_HOUR, hour_presses);
    mode       = clock_panel_pkg::TIMER_DISP;
    exp_blink  = blink_for_mode(clock_panel_pkg::TIMER_DISP, exp_ring);
    exp_preset = exp_hms;
    request_check();
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("error: %s = %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  always @(negedge clk) begin
    if (set_time === 1'b1) set_pulses++;
  end

  initial begin : compare
    clock_panel_pkg::digit_t exp_digit [`NUM_DIGITS];
    forever begin
      wait (check_pending == 1'b1);
      repeat (4) @(posedge clk);  // settle
      @(negedge clk);
      for (int i = 0; i < `NUM_DIGITS; i++) begin
        exp_digit[i] = exp_reset_state ? 4'd0 : expected_digit(exp_hms, i);  // all 0 in reset
      end
      check_value("led7", 32'(led7), 32'(exp_digit[7]));
      check_value("led6", 32'(led6), 32'(exp_digit[6]));
      check_value("led5", 32'(led5), 32'(exp_digit[5]));
      check_value("led4", 32'(led4), 32'(exp_digit[4]));
      check_value("led3", 32'(led3), 32'(exp_digit[3]));
      check_value("led2", 32'(led2), 32'(exp_digit[2]));
      check_value("led1", 32'(led1), 32'(exp_digit[1]));
      check_value("led0", 32'(led0), 32'(exp_digit[0]));
      check_value("blink", 32'(blink), 32'(exp_blink));
      check_value("ring", 32'(ring), 32'(exp_ring));
      check_value("set_time pulses", 32'(set_pulses), 32'(exp_set_pulses));
      if (check_set) begin
        check_value("set_hour", 32'(set_hour), 32'(exp_set.hour));
        check_value("set_minute", 32'(set_minute), 32'(exp_set.minute));
        check_value("set_second", 32'(set_second), 32'(exp_set.second));
      end
      check_pending = 1'b0;
    end
  end

  initial begin : watchdog
    repeat (max_presses * 6 + max_ticks * 4 + 200) @(posedge clk);
    $display("timeout: the test sequence did not finish in time");
    $display("=== FAIL ===");
    $finish;
  end

  initial begin : stimulus
    int ticks;
    rst_n       = 1'b0;
    mode        = clock_panel_pkg::TIME_DISP;
    tick        = 1'b0;
    up_btn      = 1'b1;
    down_btn    = 1'b1;
    time_hour   = 8'h00;
    time_minute = 8'h00;
    time_second = 8'h00;
    exp_hms     = '0;
    exp_blink   = `BLINK_NONE;
    exp_ring    = 1'b0;
    exp_reset_state = 1'b1;
    check_pending   = 1'b1;  // sampled while rst_n is still low
    repeat (5) @(posedge clk);
    #1;
    wait (check_pending == 1'b0);
    exp_reset_state = 1'b0;
    rst_n = 1'b1;
    request_check();

    repeat (6) begin  // live time display
      time_hour   = bin_to_bcd(rand_below(24));
      time_minute = bin_to_bcd(rand_below(60));
      time_second = bin_to_bcd(rand_below(60));
      exp_hms     = {time_hour, time_minute, time_second};
      request_check();
    end

    edit_field(clock_panel_pkg::TIME_EDIT_SECOND, rand_below(71));
    edit_field(clock_panel_pkg::TIME_EDIT_MINUTE, rand_below(71));
    edit_field(clock_panel_pkg::TIME_EDIT_HOUR, rand_below(71));
    exp_set   = exp_hms;
    exp_hms   = {time_hour, time_minute, time_second};
    mode      = clock_panel_pkg::TIME_DISP;
    exp_blink = `BLINK_NONE;
    exp_set_pulses++;
    check_set = 1'b1;
    request_check();

    preset_timer(rand_below(60), 1 + rand_below(10), rand_below(3));
    press_button(1'b0);  // play
    ticks = 1 + rand_below(59);
    apply_ticks(ticks);
    exp_hms = hms_countdown(exp_preset, ticks);
    request_check();
    press_button(1'b1);  // pause
    apply_ticks(1 + rand_below(10));
    request_check();

    preset_timer(3, 0, 0);
    press_button(1'b0);
    apply_ticks(5);  // runs out, then one idle tick
    exp_hms   = hms_countdown(exp_preset, 5);
    exp_ring  = 1'b1;
    exp_blink = blink_for_mode(clock_panel_pkg::TIMER_DISP, 1'b1);
    request_check();
    press_button(1'b1);  // rewind
    exp_hms   = exp_preset;
    exp_ring  = 1'b0;
    exp_blink = `BLINK_NONE;
    request_check();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- hdl/clock_panel.sv
`timescale 1ns/1ps
`include "clock_panel_consts.svh"

module clock_panel (
  input  logic                    clk,
  input  logic                    rst_n,
  input  clock_panel_pkg::mode_e  mode,
  input  logic                    tick,
  input  logic                    up_btn,
  input  logic                    down_btn,
  input  logic [`BCD_W-1:0]       time_hour,
  input  logic [`BCD_W-1:0]       time_minute,
  input  logic [`BCD_W-1:0]       time_second,
  output clock_panel_pkg::digit_t led0,
  output clock_panel_pkg::digit_t led1,
  output clock_panel_pkg::digit_t led2,
  output clock_panel_pkg::digit_t led3,
  output clock_panel_pkg::digit_t led4,
  output clock_panel_pkg::digit_t led5,
  output clock_panel_pkg::digit_t led6,
  output clock_panel_pkg::digit_t led7,
  output logic [`NUM_DIGITS-1:0]  blink,
  output logic                    ring,
  output logic                    set_time,
  output logic [`BCD_W-1:0]       set_hour,
  output logic [`BCD_W-1:0]       set_minute,
  output logic [`BCD_W-1:0]       set_second
);

  clock_panel_pkg::src_e   src;
  clock_panel_pkg::field_e field;
  logic                    inc;
  logic                    commit_time;
  clock_panel_pkg::mode_e  mode_q;
  clock_panel_pkg::hms_t   time_in;
  clock_panel_pkg::hms_t   edit;
  clock_panel_pkg::hms_t   set_value;
  clock_panel_pkg::digit_t digits [`NUM_DIGITS];

  timer_ctl_if tctl ();

  assign time_in = {time_hour, time_minute, time_second};

  panel_control panel_control_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .mode        (mode),
    .up_btn      (up_btn),
    .down_btn    (down_btn),
    .src         (src),
    .field       (field),
    .inc         (inc),
    .commit_time (commit_time),
    .mode_q      (mode_q),
    .tctl        (tctl.ctrl)
  );

  bcd_field_editor bcd_field_editor_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .src         (src),
    .field       (field),
    .inc         (inc),
    .commit_time (commit_time),
    .time_in     (time_in),
    .timer_value (tctl.value),
    .edit        (edit),
    .set_time    (set_time),
    .set_value   (set_value)
  );

  countdown_timer countdown_timer_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .tick         (tick),
    .preset_value (edit),
    .tctl         (tctl.timer)
  );

  digit_formatter digit_formatter_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .mode_q (mode_q),
    .edit   (edit),
    .ring   (tctl.ring),
    .digits (digits),
    .blink  (blink)
  );

  assign led0 = digits[0];
  assign led1 = digits[1];
  assign led2 = digits[2];
  assign led3 = digits[3];
  assign led4 = digits[4];
  assign led5 = digits[5];
  assign led6 = digits[6];
  assign led7 = digits[7];

  assign ring       = tctl.ring;
  assign set_hour   = set_value.hour;
  assign set_minute = set_value.minute;
  assign set_second = set_value.second;

endmodule

//--- hdl/digit_formatter.sv
`timescale 1ns/1ps
`include "clock_panel_consts.svh"

module digit_formatter (
  input  logic                    clk,
  input  logic                    rst_n,
  input  clock_panel_pkg::mode_e  mode_q,
  input  clock_panel_pkg::hms_t   edit,
  input  logic                    ring,
  output clock_panel_pkg::digit_t digits [`NUM_DIGITS],
  output logic [`NUM_DIGITS-1:0]  blink
);

  clock_panel_pkg::digit_t layout  [`NUM_DIGITS];
  clock_panel_pkg::digit_t digit_q [`NUM_DIGITS];

  // H H - M M - S S, digit 7 leftmost
  always_comb begin
    layout[7] = edit.hour[7:4];
    layout[6] = edit.hour[3:0];
    layout[5] = `DIGIT_SEP;
    layout[4] = edit.minute[7:4];
    layout[3] = edit.minute[3:0];
    layout[2] = `DIGIT_SEP;
    layout[1] = edit.second[7:4];
    layout[0] = edit.second[3:0];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `NUM_DIGITS; i++) begin
        digit_q[i] <= '0;
        digits[i]  <= '0;
      end
      blink <= `BLINK_NONE;
    end else begin
      digit_q <= layout;
      digits  <= digit_q;  // output stage
      case (mode_q)
        clock_panel_pkg::TIME_EDIT_SECOND, clock_panel_pkg::TIMER_EDIT_SECOND:
          blink <= `BLINK_SECOND;
        clock_panel_pkg::TIME_EDIT_MINUTE, clock_panel_pkg::TIMER_EDIT_MINUTE:
          blink <= `BLINK_MINUTE;
        clock_panel_pkg::TIME_EDIT_HOUR, clock_panel_pkg::TIMER_EDIT_HOUR:
          blink <= `BLINK_HOUR;
        clock_panel_pkg::TIMER_DISP:
          blink <= ring ? `BLINK_ALL : `BLINK_NONE;  // flash whole panel
        default:
          blink <= `BLINK_NONE;
      endcase
    end
  end

endmodule

//--- hdl/countdown_timer.sv
`timescale 1ns/1ps
`include "clock_panel_consts.svh"

module countdown_timer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  tick,
  input  clock_panel_pkg::hms_t preset_value,
  timer_ctl_if.timer            tctl
);

  clock_panel_pkg::hms_t preset;

  // -1 on one field, 00 wraps to max
  function automatic logic [`BCD_W-1:0] bcd_dec(input logic [`BCD_W-1:0] val,
                                                input logic [`BCD_W-1:0] max);
    if (val == '0) begin
      return max;
    end else if (val[3:0] == 4'd0) begin
      return {val[7:4] - 4'd1, 4'd9};
    end else begin
      return val - 1'b1;
    end
  endfunction

  function automatic clock_panel_pkg::hms_t hms_dec(input clock_panel_pkg::hms_t t);
    clock_panel_pkg::hms_t r;
    r        = t;
    r.second = bcd_dec(t.second, `SECOND_MAX);
    if (t.second == '0) begin
      r.minute = bcd_dec(t.minute, `MINUTE_MAX);  // borrow
      if (t.minute == '0) begin
        r.hour = bcd_dec(t.hour, `HOUR_MAX);
      end
    end
    return r;
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      preset        <= '0;
      tctl.value    <= '0;
      tctl.counting <= 1'b0;
      tctl.ring     <= 1'b0;
    end else if (tctl.preset_load) begin
      preset     <= preset_value;
      tctl.value <= preset_value;
      tctl.ring  <= 1'b0;
    end else if (tctl.rewind) begin
      tctl.value <= preset;
      tctl.ring  <= 1'b0;
    end else if (tctl.play) begin
      tctl.counting <= (tctl.value != '0);  // nothing to count at zero
      tctl.ring     <= 1'b0;
    end else if (tctl.pause) begin
      tctl.counting <= 1'b0;
    end else if (tick && tctl.counting) begin
      if (tctl.value == '0) begin
        tctl.counting <= 1'b0;
        tctl.ring     <= 1'b1;  // expired
      end else begin
        tctl.value <= hms_dec(tctl.value);
      end
    end
  end

  a_ring_idle: assert property (
    @(posedge clk) disable iff (!rst_n) !(tctl.ring && tctl.counting)
  );

endmodule

//--- hdl/bcd_field_editor.sv
`timescale 1ns/1ps
`include "clock_panel_consts.svh"

module bcd_field_editor (
  input  logic                    clk,
  input  logic                    rst_n,
  input  clock_panel_pkg::src_e   src,
  input  clock_panel_pkg::field_e field,
  input  logic                    inc,
  input  logic                    commit_time,
  input  clock_panel_pkg::hms_t   time_in,
  input  clock_panel_pkg::hms_t   timer_value,
  output clock_panel_pkg::hms_t   edit,
  output logic                    set_time,
  output clock_panel_pkg::hms_t   set_value
);

  // +1 with carry into tens, max wraps to 00
  function automatic logic [`BCD_W-1:0] bcd_inc(input logic [`BCD_W-1:0] val,
                                                input logic [`BCD_W-1:0] max);
    if (val == max) begin
      return '0;
    end else if (val[3:0] == 4'd9) begin
      return {val[7:4] + 4'd1, 4'd0};
    end else begin
      return val + 1'b1;
    end
  endfunction

  function automatic logic field_ok(input logic [`BCD_W-1:0] val,
                                    input logic [`BCD_W-1:0] max);
    return (val[3:0] <= 4'd9) && (val <= max);
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      edit <= '0;
    end else begin
      case (src)
        clock_panel_pkg::SRC_TIME: begin
          edit <= time_in;  // track live time
        end
        clock_panel_pkg::SRC_TIMER: begin
          edit <= timer_value;
        end
        default: begin
          if (inc) begin
            case (field)
              clock_panel_pkg::FIELD_SECOND: begin
                edit.second <= bcd_inc(edit.second, `SECOND_MAX);
              end
              clock_panel_pkg::FIELD_MINUTE: begin
                edit.minute <= bcd_inc(edit.minute, `MINUTE_MAX);
              end
              clock_panel_pkg::FIELD_HOUR: begin
                edit.hour <= bcd_inc(edit.hour, `HOUR_MAX);
              end
              default: begin
                edit <= edit;
              end
            endcase
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      set_time <= 1'b0;
    end else begin
      set_time <= commit_time;
    end
  end

  always_ff @(posedge clk) begin
    if (commit_time) begin
      set_value <= edit;  // held until next commit
    end
  end

  a_edit_legal: assert property (
    @(posedge clk) disable iff (!rst_n)
    inc |=> field_ok(edit.second, `SECOND_MAX) && field_ok(edit.minute, `MINUTE_MAX)
            && field_ok(edit.hour, `HOUR_MAX)
  );

endmodule

//--- hdl/panel_control.sv
`timescale 1ns/1ps

module panel_control (
  input  logic                    clk,
  input  logic                    rst_n,
  input  clock_panel_pkg::mode_e  mode,
  input  logic                    up_btn,
  input  logic                    down_btn,
  output clock_panel_pkg::src_e   src,
  output clock_panel_pkg::field_e field,
  output logic                    inc,
  output logic                    commit_time,
  output clock_panel_pkg::mode_e  mode_q,
  timer_ctl_if.ctrl               tctl
);

  logic [1:0] up_buf;
  logic [1:0] down_buf;
  logic       up_press;
  logic       down_press;
  logic       timer_disp;
  logic       prev_time_edit;
  logic       prev_timer_edit;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      up_buf   <= 2'b11;  // released
      down_buf <= 2'b11;
      mode_q   <= clock_panel_pkg::TIME_DISP;
    end else begin
      up_buf   <= {up_buf[0], up_btn};
      down_buf <= {down_buf[0], down_btn};
      mode_q   <= mode;
    end
  end

  assign up_press   = (up_buf == 2'b10);  // falling edge
  assign down_press = (down_buf == 2'b10);

  always_comb begin
    src   = clock_panel_pkg::SRC_HOLD;
    field = clock_panel_pkg::FIELD_NONE;
    case (mode)
      clock_panel_pkg::TIME_DISP: begin
        src = clock_panel_pkg::SRC_TIME;
      end
      clock_panel_pkg::TIMER_DISP: begin
        src = clock_panel_pkg::SRC_TIMER;
      end
      clock_panel_pkg::TIME_EDIT_SECOND, clock_panel_pkg::TIMER_EDIT_SECOND: begin
        field = clock_panel_pkg::FIELD_SECOND;
      end
      clock_panel_pkg::TIME_EDIT_MINUTE, clock_panel_pkg::TIMER_EDIT_MINUTE: begin
        field = clock_panel_pkg::FIELD_MINUTE;
      end
      clock_panel_pkg::TIME_EDIT_HOUR, clock_panel_pkg::TIMER_EDIT_HOUR: begin
        field = clock_panel_pkg::FIELD_HOUR;
      end
      default: begin
        src = clock_panel_pkg::SRC_HOLD;
      end
    endcase
  end

  assign inc = down_press && (field != clock_panel_pkg::FIELD_NONE);

  assign prev_time_edit = mode_q inside {clock_panel_pkg::TIME_EDIT_SECOND,
                                         clock_panel_pkg::TIME_EDIT_MINUTE,
                                         clock_panel_pkg::TIME_EDIT_HOUR};
  assign prev_timer_edit = mode_q inside {clock_panel_pkg::TIMER_EDIT_SECOND,
                                          clock_panel_pkg::TIMER_EDIT_MINUTE,
                                          clock_panel_pkg::TIMER_EDIT_HOUR};

  // leaving an edit mode hands the edit value over
  assign commit_time      = prev_time_edit && (mode == clock_panel_pkg::TIME_DISP);
  assign tctl.preset_load = prev_timer_edit && (mode == clock_panel_pkg::TIMER_DISP);

  assign timer_disp  = (mode == clock_panel_pkg::TIMER_DISP);
  assign tctl.play   = timer_disp && down_press && !tctl.counting;
  assign tctl.pause  = timer_disp && up_press && tctl.counting;
  assign tctl.rewind = timer_disp && up_press && !tctl.counting;

  // timer must stop one edge after a pause
  a_pause_stops: assert property (
    @(posedge clk) disable iff (!rst_n) tctl.pause && !tctl.preset_load |=> !tctl.counting
  );

endmodule

//--- hdl/timer_ctl_if.sv
`timescale 1ns/1ps

interface timer_ctl_if;
  logic                  preset_load;  // one-cycle pulses from control
  logic                  play;
  logic                  pause;
  logic                  rewind;
  logic                  counting;     // levels from timer
  logic                  ring;
  clock_panel_pkg::hms_t value;

  modport ctrl (
    output preset_load, play, pause, rewind,
    input  counting
  );

  modport timer (
    input  preset_load, play, pause, rewind,
    output counting, ring, value
  );

endinterface

//--- hdl/clock_panel_pkg.sv
`include "clock_panel_consts.svh"

package clock_panel_pkg;

  typedef enum logic [2:0] {
    TIME_DISP         = 3'd0,
    TIME_EDIT_SECOND  = 3'd1,
    TIME_EDIT_MINUTE  = 3'd2,
    TIME_EDIT_HOUR    = 3'd3,
    TIMER_DISP        = 3'd4,
    TIMER_EDIT_SECOND = 3'd5,
    TIMER_EDIT_MINUTE = 3'd6,
    TIMER_EDIT_HOUR   = 3'd7
  } mode_e;

  typedef enum logic [1:0] {
    FIELD_NONE   = 2'd0,
    FIELD_SECOND = 2'd1,
    FIELD_MINUTE = 2'd2,
    FIELD_HOUR   = 2'd3
  } field_e;

  typedef enum logic [1:0] {
    SRC_HOLD  = 2'd0,
    SRC_TIME  = 2'd1,
    SRC_TIMER = 2'd2
  } src_e;

  typedef logic [3:0] digit_t;

  typedef struct packed {
    logic [`BCD_W-1:0] hour;    // two bcd digits each
    logic [`BCD_W-1:0] minute;
    logic [`BCD_W-1:0] second;
  } hms_t;

endpackage

//--- hdl/clock_panel_consts.svh
`ifndef CLOCK_PANEL_CONSTS_SVH
`define CLOCK_PANEL_CONSTS_SVH

// one hh, mm or ss field
`define BCD_W 8
`define NUM_DIGITS 8

// field wrap limits, bcd
`define SECOND_MAX 8'h59
`define MINUTE_MAX 8'h59
`define HOUR_MAX 8'h23

`define DIGIT_SEP 4'd10  // dash between fields

// bit i blinks digit i
`define BLINK_SECOND 8'h03
`define BLINK_MINUTE 8'h18
`define BLINK_HOUR 8'hC0
`define BLINK_ALL 8'hFF
`define BLINK_NONE 8'h00

`endif
